// File: flist.f
+incdir+verilog
+incdir+verif
verilog/ulaPkg.sv
verilog/screenFetch.sv
verilog/pixelSerializer.sv
verilog/colourMapper.sv
verilog/cpuPorts.sv
verilog/ulaVideo.sv
verif/tbUlaVideo.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then decide on the simulation log
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module tbUlaVideo \
   -f flist.f -o simUlaVideo \
   && ./obj_dir/simUlaVideo > sim.log 2>&1
grep -q ">>> FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "No result in sim.log"; exit 1; }
echo "Simulation passed"

// File: verif/tbChecks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////
// Wishbone master
task automatic accessPort(input logic we, input logic [15:0] adr, input logic [7:0] wdat,
                          output logic [7:0] rdat);
   int waitCycles;
   @(negedge clk7);
   wbCyc      = 1'b1;
   wbStb      = 1'b1;
   wbWe       = we;
   wbAdr      = adr;
   wbDatW     = wdat;
   waitCycles = 0;
   do begin
      @(negedge clk7);
      waitCycles++;
   end while (!wbAck && waitCycles < 16);
   if (!wbAck)
      failRun($sformatf("No wbAck for the access at address %h", adr));
   checkByte($sformatf("wbAck latency at %h", adr), 8'd1, 8'(waitCycles));
   rdat  = wbDatR;
   wbCyc = 1'b0;
   wbStb = 1'b0;
   wbWe  = 1'b0;
   @(negedge clk7);
   checkBit($sformatf("single wbAck at %h", adr), 1'b0, wbAck);
endtask

task automatic writePort(input logic [15:0] adr, input logic [7:0] data);
   logic [7:0] ignored;
   accessPort(1'b1, adr, data, ignored);
endtask

task automatic readPort(input logic [15:0] adr, output logic [7:0] data);
   accessPort(1'b0, adr, 8'h00, data);
endtask

////////////////////
// Compare tasks
task automatic checkGrb9(input string name, input grb9T expected, input grb9T actual);
   if (actual !== expected)
      failRun($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
endtask

task automatic checkByte(input string name, input logic [7:0] expected,
                         input logic [7:0] actual);
   if (actual !== expected)
      failRun($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
endtask

task automatic checkBit(input string name, input logic expected, input logic actual);
   if (actual !== expected)
      failRun($sformatf("FAILED %s: expected %b, actual %b", name, expected, actual));
endtask

////////////////////
// Directed tests
task automatic portFeAccess();
   logic [7:0] data;
   // Speaker on, border 5
   writePort(16'h00FE, 8'h15);
   borderModel = 3'd5;
   checkBit("port FE spk set", 1'b1, spk);
   checkBit("port FE mic clear", 1'b0, mic);
   writePort(16'h7FFE, 8'h0B);
   borderModel = 3'd3;
   checkBit("port FE mic set", 1'b1, mic);
   checkBit("port FE spk clear", 1'b0, spk);
   ear = 1'b1;
   kbd = 5'b10110;
   readPort(16'hFEFE, data);
   checkByte("port FE read", 8'hF6, data);
   ear = 1'b0;
   kbd = 5'($urandom);
   readPort(16'h00FE, data);
   checkByte("port FE read random keys", {1'b1, ear, 1'b1, kbd}, data);
   readPort(16'h00FF, data);
   checkByte("unmapped read", 8'hFF, data);
endtask

task automatic syncAndInterrupt();
   int lowCount;
   lowCount = 0;
   waitUntil(`VSYNC_BEGIN - 2, 0);
   repeat (8 * `H_TOTAL) begin
      checkBit($sformatf("int_n line %0d hc %0d", vcModel, hcModel),
               !(vcModel == `VSYNC_BEGIN && hcModel < `INT_WIDTH), int_n);
      checkBit($sformatf("hSync hc %0d", hcModel),
               hcModel >= `HSYNC_BEGIN && hcModel <= `HSYNC_END, hSync);
      checkBit($sformatf("vSync line %0d", vcModel),
               vcModel >= `VSYNC_BEGIN && vcModel <= `VSYNC_END, vSync);
      if (!int_n)
         lowCount++;
      @(negedge clk7);
   end
   checkByte("int_n low cycles", 8'(`INT_WIDTH), 8'(lowCount));
endtask

task automatic borderAndPaper();
   logic [7:0] pick;
   pick = 8'($urandom);
   writePort(16'h00FE, {5'b00000, pick[2:0]});
   borderModel = pick[2:0];
   scanLine("border and paper", 0);
   scanLine("border and paper", 97);
   scanLine("border and paper", 191);
   scanLine("border and paper", 192);
   scanLine("border and paper", 300);
endtask

task automatic flashInversion();
   logic [13:0] addr;
   // Attribute row 8 alternates flash set and flash clear cells
   for (int col = 0; col < 32; col++) begin
      addr       = 14'h1900 + 14'(col);
      vram[addr] = (col % 2 == 0) ? (vram[addr] | 8'h80) : (vram[addr] & 8'h7F);
   end
   scanLine("flash phase 0", 64);
   while (frameTicks < `FLASH_FRAMES)
      @(negedge clk7);
   scanLine("flash phase 1", 64);
endtask

task automatic paletteReadback();
   logic [7:0] data;
   logic [5:0] idx;
   grb8T       entry;
   for (int i = 0; i < 64; i++) begin
      idx           = 6'(i);
      entry         = 8'($urandom);
      palModel[idx] = entry;
      writePort(`PORT_ULAPLUS_ADDR, {2'b00, idx});
      writePort(`PORT_ULAPLUS_DATA, entry);
   end
   // Read back once every entry holds its own value
   for (int i = 0; i < 64; i++) begin
      idx = 6'(i);
      writePort(`PORT_ULAPLUS_ADDR, {2'b00, idx});
      readPort(`PORT_ULAPLUS_DATA, data);
      checkByte($sformatf("palette entry %0d", i), palModel[idx], data);
   end
   // Bit 6 selects the config register
   writePort(`PORT_ULAPLUS_ADDR, 8'h40);
   readPort(`PORT_ULAPLUS_ADDR, data);
   checkByte("palette register", 8'h40, data);
   writePort(`PORT_ULAPLUS_DATA, 8'h01);
   ulaplusModel = 1'b1;
   readPort(`PORT_ULAPLUS_DATA, data);
   checkByte("config register", 8'h01, data);
endtask

task automatic ulaplusPixels();
   // Flash phase is 1 by now and the flash row keeps its pixels
   scanLine("ULAplus flash row", 71);
   scanLine("ULAplus paper", 150);
   scanLine("ULAplus border", 220);
endtask

`endif

// File: verif/tbUlaVideo.sv
`timescale 1ns/1ps
`include "ulaVideo_cfg.svh"

module tbUlaVideo import ulaPkg::*; ();

   localparam int CYCLE_LIMIT = 20 * `H_TOTAL * `V_TOTAL;

   logic        clk7;
   logic        rst_n;
   logic        wbCyc;
   logic        wbStb;
   logic        wbWe;
   logic [15:0] wbAdr;
   logic [7:0]  wbDatW;
   logic [7:0]  wbDatR;
   logic        wbAck;
   logic [7:0]  vramData;
   logic [13:0] vramAddr;
   logic        ear;
   logic [4:0]  kbd;
   logic [2:0]  r;
   logic [2:0]  g;
   logic [2:0]  b;
   logic        hSync;
   logic        vSync;
   logic        int_n;
   logic        mic;
   logic        spk;

   // VRAM model and expected DUT state
   logic [7:0]  vram [0:16383];
   grb8T        palModel [0:63];
   logic [2:0]  borderModel;
   logic        ulaplusModel;
   int          hcModel;
   int          vcModel;
   int          frameTicks;
   int          cycles = 0;

   ulaVideo DUT (
      .clk7(clk7), .rst_n(rst_n), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
      .wbAdr(wbAdr), .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
      .vramData(vramData), .ear(ear), .kbd(kbd), .vramAddr(vramAddr),
      .r(r), .g(g), .b(b), .hSync(hSync), .vSync(vSync), .int_n(int_n),
      .mic(mic), .spk(spk)
   );

   assign vramData = vram[vramAddr];

   initial begin
      clk7 = 1'b0;
      forever #50 clk7 = ~clk7;
   end

   ////////////////////
   // Frame position tracker
   always @(posedge clk7) begin
      if (!rst_n) begin
         hcModel    <= 0;
         vcModel    <= 0;
         frameTicks <= 0;
      end else begin
         if (hcModel == 0 && vcModel == `VSYNC_BEGIN)
            frameTicks <= frameTicks + 1;
         if (hcModel == `H_TOTAL - 1) begin
            hcModel <= 0;
            vcModel <= (vcModel + 1) % `V_TOTAL;
         end else begin
            hcModel <= hcModel + 1;
         end
      end
   end

   always @(posedge clk7) begin
      cycles++;
      if (cycles == CYCLE_LIMIT)
         failRun("Timeout: the test sequence did not finish within 20 frames");
   end

   task automatic failRun(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   // Expected r/g/b while hc is hPos on the given line
   function automatic grb9T colourAt(input int line, input int hPos);
      int         x;
      logic [8:0] ln;
      logic [8:0] xv;
      logic [7:0] bitmap;
      attrT       attr;
      logic       bitSet;
      logic       inkSel;
      igrbT       idx;
      grb8T       entry;
      logic [2:0] full;
      grb9T       colour;
      x          = (hPos - `PIXEL_LAG + `H_TOTAL) % `H_TOTAL;
      ln         = 9'(line);
      xv         = 9'(x);
      attr       = '0;
      attr.paper = borderModel;
      bitSet     = 1'b0;
      if (line < `PAPER_H && x < `PAPER_W) begin
         bitmap = vram[{1'b0, ln[7:6], ln[2:0], ln[5:3], xv[7:3]}];
         attr   = vram[{1'b0, 3'b110, ln[7:3], xv[7:3]}];
         bitSet = bitmap[3'd7 - xv[2:0]];
      end
      if (ulaplusModel) begin
         entry  = bitSet ? palModel[{attr.flash, attr.bright, 1'b0, attr.ink}] :
                           palModel[{attr.flash, attr.bright, 1'b1, attr.paper}];
         colour = {entry.green, entry.red, entry.blue, entry.blue[1]};
      end else begin
         inkSel       = bitSet ^ (attr.flash && ((frameTicks / `FLASH_FRAMES) % 2 == 1));
         idx          = inkSel ? {attr.bright, attr.ink} : {attr.bright, attr.paper};
         full         = idx.bright ? 3'b111 : 3'b101;
         colour.green = idx.green ? full : 3'b000;
         colour.red   = idx.red ? full : 3'b000;
         colour.blue  = idx.blue ? full : 3'b000;
      end
      return colour;
   endfunction

   task automatic waitUntil(input int line, input int hPos);
      @(negedge clk7);
      while (vcModel != line || hcModel != hPos)
         @(negedge clk7);
   endtask

   task automatic scanLine(input string name, input int line);
      waitUntil(line, 0);
      repeat (`H_TOTAL) begin
         checkGrb9($sformatf("%s line %0d hc %0d", name, line, hcModel),
                   colourAt(vcModel, hcModel), {g, r, b});
         @(negedge clk7);
      end
   endtask

   `include "tbChecks.svh"

   initial begin
      logic [13:0] addr;
      void'($urandom(32'ha30a_36c7));
      rst_n        = 1'b0;
      wbCyc        = 1'b0;
      wbStb        = 1'b0;
      wbWe         = 1'b0;
      wbAdr        = '0;
      wbDatW       = '0;
      ear          = 1'b0;
      kbd          = '0;
      borderModel  = 3'b010;
      ulaplusModel = 1'b0;
      for (int i = 0; i < 16384; i++) begin
         addr       = 14'(i);
         vram[addr] = 8'($urandom);
      end
      repeat (3) @(posedge clk7);
      @(negedge clk7);
      rst_n = 1'b1;
      checkBit("int_n after reset", 1'b1, int_n);
      checkBit("wbAck after reset", 1'b0, wbAck);
      checkBit("mic after reset", 1'b0, mic);
      checkBit("spk after reset", 1'b0, spk);

      portFeAccess();
      syncAndInterrupt();
      borderAndPaper();
      flashInversion();
      paletteReadback();
      ulaplusPixels();

      $display(">>> PASS");
      $finish;
   end

endmodule

// File: verilog/ulaVideo.sv
`timescale 1ns/1ps

module ulaVideo import ulaPkg::*; (
   input  logic        clk7,
   input  logic        rst_n,
   input  logic        wbCyc,
   input  logic        wbStb,
   input  logic        wbWe,
   input  logic [15:0] wbAdr,
   input  logic [7:0]  wbDatW,
   output logic [7:0]  wbDatR,
   output logic        wbAck,
   input  logic [7:0]  vramData,
   input  logic        ear,
   input  logic [4:0]  kbd,
   output logic [13:0] vramAddr,
   output logic [2:0]  r,
   output logic [2:0]  g,
   output logic [2:0]  b,
   output logic        hSync,
   output logic        vSync,
   output logic        int_n,
   output logic        mic,
   output logic        spk
);

   logic [7:0] bitmapByte;
   attrT       attrByte;
   logic       serialLoad;
   logic       attrLoad;
   logic       paperActive;
   logic       flashPhase;
   logic       pixelOn;
   logic       pixelRaw;
   attrT       attrOut;
   logic [2:0] border;
   logic       ulaplusEnable;
   logic       palWrite;
   palIndexT   palIndex;
   grb8T       palWriteData;
   grb8T       palReadData;

   screenFetch fetch (
      .clk7(clk7), .rst_n(rst_n), .vramData(vramData), .vramAddr(vramAddr),
      .bitmapByte(bitmapByte), .attrByte(attrByte), .serialLoad(serialLoad),
      .attrLoad(attrLoad), .paperActive(paperActive), .flashPhase(flashPhase),
      .hCount(), .int_n(int_n), .hSync(hSync), .vSync(vSync)
   );

   pixelSerializer serializer (
      .clk7(clk7), .rst_n(rst_n), .bitmapByte(bitmapByte), .attrByte(attrByte),
      .serialLoad(serialLoad), .attrLoad(attrLoad), .paperActive(paperActive),
      .flashPhase(flashPhase), .border(border), .pixelOn(pixelOn),
      .pixelRaw(pixelRaw), .attrOut(attrOut)
   );

   colourMapper mapper (
      .clk7(clk7), .rst_n(rst_n), .pixelOn(pixelOn), .pixelRaw(pixelRaw),
      .attrOut(attrOut), .ulaplusEnable(ulaplusEnable), .palWrite(palWrite),
      .palIndex(palIndex), .palWriteData(palWriteData), .palReadData(palReadData),
      .r(r), .g(g), .b(b)
   );

   cpuPorts ports (
      .clk7(clk7), .rst_n(rst_n), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
      .wbAdr(wbAdr), .wbDatW(wbDatW), .ear(ear), .kbd(kbd),
      .palReadData(palReadData), .wbDatR(wbDatR), .wbAck(wbAck), .border(border),
      .mic(mic), .spk(spk), .palWrite(palWrite), .palIndex(palIndex),
      .palWriteData(palWriteData), .ulaplusEnable(ulaplusEnable)
   );

endmodule

// File: verilog/cpuPorts.sv
`timescale 1ns/1ps
`include "ulaVideo_cfg.svh"

module cpuPorts import ulaPkg::*; (
   input  logic        clk7,
   input  logic        rst_n,
   input  logic        wbCyc,
   input  logic        wbStb,
   input  logic        wbWe,
   input  logic [15:0] wbAdr,
   input  logic [7:0]  wbDatW,
   input  logic        ear,
   input  logic [4:0]  kbd,
   input  grb8T        palReadData,
   output logic [7:0]  wbDatR,
   output logic        wbAck,
   output logic [2:0]  border,
   output logic        mic,
   output logic        spk,
   output logic        palWrite,
   output palIndexT    palIndex,
   output grb8T        palWriteData,
   output logic        ulaplusEnable
);

   logic       access;
   logic       portFe;
   logic       portPlusAddr;
   logic       portPlusData;
   logic [6:0] paletteReg;
   logic       configReg;
   logic [7:0] readMux;

   // New request, one wait state before ack
   assign access       = wbCyc && wbStb && !wbAck;
   assign portFe       = !wbAdr[0];
   assign portPlusAddr = (wbAdr == `PORT_ULAPLUS_ADDR);
   assign portPlusData = (wbAdr == `PORT_ULAPLUS_DATA);

   always_ff @(posedge clk7) begin
      if (!rst_n)
         wbAck <= 1'b0;
      else
         wbAck <= access;
   end

   ////////////////////
   // Port registers
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         border     <= 3'b010;
         mic        <= 1'b0;
         spk        <= 1'b0;
         paletteReg <= '0;
         configReg  <= 1'b0;
      end else if (access && wbWe) begin
         if (portFe) begin
            border <= wbDatW[2:0];
            mic    <= wbDatW[3];
            spk    <= wbDatW[4];
         end else if (portPlusAddr) begin
            paletteReg <= wbDatW[6:0];
         end else if (portPlusData && paletteReg[6]) begin
            configReg <= wbDatW[0];
         end
      end
   end

   // Palette entry writes go straight to the mapper's RAM
   assign palWrite      = access && wbWe && portPlusData && !paletteReg[6];
   assign palIndex      = paletteReg[5:0];
   assign palWriteData  = wbDatW;
   assign ulaplusEnable = configReg;

   always_comb begin
      readMux = 8'hFF;
      if (portFe)
         readMux = {1'b1, ear, 1'b1, kbd};
      else if (portPlusAddr)
         readMux = {1'b0, paletteReg};
      else if (portPlusData)
         readMux = paletteReg[6] ? {7'b0, configReg} : palReadData;
   end

   always_ff @(posedge clk7) begin
      if (access)
         wbDatR <= readMux;
   end

   singleAck: assert property (@(posedge clk7) disable iff (!rst_n)
      wbAck |=> !wbAck);

endmodule

// File: verilog/colourMapper.sv
`timescale 1ns/1ps

module colourMapper import ulaPkg::*; (
   input  logic       clk7,
   input  logic       rst_n,
   input  logic       pixelOn,
   input  logic       pixelRaw,
   input  attrT       attrOut,
   input  logic       ulaplusEnable,
   input  logic       palWrite,
   input  palIndexT   palIndex,
   input  grb8T       palWriteData,
   output grb8T       palReadData,
   output logic [2:0] r,
   output logic [2:0] g,
   output logic [2:0] b
);

   grb8T     palRam [0:63];
   igrbT     stdIndex;
   grb9T     stdColour;
   palIndexT plusIndex;
   grb8T     plusEntry;
   grb9T     plusColour;
   grb9T     outColour;

   // Set channel is half level, full level when bright
   function automatic logic [2:0] channelLevel(input logic on, input logic bright);
      if (!on)
         return 3'b000;
      return bright ? 3'b111 : 3'b101;
   endfunction

   ////////////////////
   // ULAplus palette
   always_ff @(posedge clk7) begin
      if (palWrite)
         palRam[palIndex] <= palWriteData;
   end

   assign palReadData = palRam[palIndex];

   always_comb begin
      // Standard IGRB path
      stdIndex        = pixelOn ? {attrOut.bright, attrOut.ink} :
                                  {attrOut.bright, attrOut.paper};
      stdColour.green = channelLevel(stdIndex.green, stdIndex.bright);
      stdColour.red   = channelLevel(stdIndex.red, stdIndex.bright);
      stdColour.blue  = channelLevel(stdIndex.blue, stdIndex.bright);

      // Ink entries in the lower half of each 16, paper in the upper
      plusIndex  = pixelRaw ? {attrOut.flash, attrOut.bright, 1'b0, attrOut.ink} :
                              {attrOut.flash, attrOut.bright, 1'b1, attrOut.paper};
      plusEntry  = palRam[plusIndex];
      plusColour = {plusEntry, plusEntry.blue[1]};

      outColour  = ulaplusEnable ? plusColour : stdColour;
   end

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         g <= '0;
         r <= '0;
         b <= '0;
      end else begin
         g <= outColour.green;
         r <= outColour.red;
         b <= outColour.blue;
      end
   end

endmodule

// File: verilog/pixelSerializer.sv
`timescale 1ns/1ps

module pixelSerializer import ulaPkg::*; (
   input  logic       clk7,
   input  logic       rst_n,
   input  logic [7:0] bitmapByte,
   input  attrT       attrByte,
   input  logic       serialLoad,
   input  logic       attrLoad,
   input  logic       paperActive,
   input  logic       flashPhase,
   input  logic [2:0] border,
   output logic       pixelOn,
   output logic       pixelRaw,
   output attrT       attrOut
);

   logic [7:0] shiftReg;
   attrT       borderAttr;

   // Border shows as paper colour, never bright or flashing
   always_comb begin
      borderAttr        = '0;
      borderAttr.paper  = border;
   end

   ////////////////////
   // Bitmap shifter, MSB first
   always_ff @(posedge clk7) begin
      if (!rst_n)
         shiftReg <= '0;
      else if (serialLoad)
         shiftReg <= bitmapByte;
      else
         shiftReg <= {shiftReg[6:0], 1'b0};
   end

   // Attribute output, reloaded every 8 pixels
   always_ff @(posedge clk7) begin
      if (!rst_n)
         attrOut <= '0;
      else if (attrLoad)
         attrOut <= paperActive ? attrByte : borderAttr;
   end

   assign pixelRaw = shiftReg[7];
   assign pixelOn  = pixelRaw ^ (attrOut.flash & flashPhase);

   loadInPaper: assert property (@(posedge clk7) disable iff (!rst_n)
      serialLoad |-> paperActive);

endmodule

// File: verilog/screenFetch.sv
`timescale 1ns/1ps
`include "ulaVideo_cfg.svh"

module screenFetch import ulaPkg::*; (
   input  logic        clk7,
   input  logic        rst_n,
   input  logic [7:0]  vramData,
   output logic [13:0] vramAddr,
   output logic [7:0]  bitmapByte,
   output attrT        attrByte,
   output logic        serialLoad,
   output logic        attrLoad,
   output logic        paperActive,
   output logic        flashPhase,
   output logic [8:0]  hCount,
   output logic        int_n,
   output logic        hSync,
   output logic        vSync
);

   localparam int FLASH_W = $clog2(`FLASH_FRAMES);

   logic [8:0]         hc;
   logic [8:0]         vc;
   logic [4:0]         column;
   logic               bitmapSlot;
   logic               attrSlot;
   logic               bitmapLatch;
   logic               attrLatch;
   logic               frameTick;
   logic [FLASH_W-1:0] flashCount;

   ////////////////////
   // Frame counters
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         hc <= '0;
         vc <= '0;
      end else if (hc == `H_TOTAL - 1) begin
         hc <= '0;
         vc <= (vc == `V_TOTAL - 1) ? 9'd0 : vc + 9'd1;
      end else begin
         hc <= hc + 9'd1;
      end
   end

   assign hCount      = hc;
   assign paperActive = (hc >= `FETCH_OFFSET) && (hc <= `PAPER_W + `FETCH_OFFSET - 1) &&
                        (vc < `PAPER_H);

   ////////////////////
   // Fetch slots
   // Phases 8/9 and 12/13 read bitmap, 10/11 and 14/15 read attributes
   assign bitmapSlot  = paperActive && hc[3] && !hc[1];
   assign attrSlot    = paperActive && hc[3] && hc[1];
   assign bitmapLatch = bitmapSlot && hc[0];
   assign attrLatch   = attrSlot && hc[0];
   assign serialLoad  = paperActive && (hc[2:0] == 3'd4);
   assign attrLoad    = (hc[2:0] == 3'd4);

   // Column advances just before each bitmap slot
   always_ff @(posedge clk7) begin
      if (!rst_n)
         column <= '0;
      else if (hc[2:0] == 3'd3)
         column <= hc[7:3];
   end

   always_comb begin
      if (attrSlot)
         vramAddr = {1'b0, 3'b110, vc[7:3], column};
      else
         vramAddr = {1'b0, vc[7:6], vc[2:0], vc[5:3], column};
   end

   always_ff @(posedge clk7) begin
      if (bitmapLatch)
         bitmapByte <= vramData;
      if (attrLatch)
         attrByte <= vramData;
   end

   ////////////////////
   // Flash, interrupt and sync
   assign frameTick = (vc == `VSYNC_BEGIN) && (hc == 9'd0);

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         flashCount <= '0;
         flashPhase <= 1'b0;
      end else if (frameTick) begin
         flashCount <= flashCount + 1'b1;
         if (flashCount == FLASH_W'(`FLASH_FRAMES - 1))
            flashPhase <= ~flashPhase;
      end
   end

   assign int_n = !((vc == `VSYNC_BEGIN) && (hc < `INT_WIDTH));
   assign hSync = (hc >= `HSYNC_BEGIN) && (hc <= `HSYNC_END);
   assign vSync = (vc >= `VSYNC_BEGIN) && (vc <= `VSYNC_END);

   slotsExclusive: assert property (@(posedge clk7) disable iff (!rst_n)
      !(bitmapSlot && attrSlot));

endmodule

// File: verilog/ulaPkg.sv
package ulaPkg;

   // Standard Spectrum colour index
   typedef struct packed {
      logic bright;
      logic green;
      logic red;
      logic blue;
   } igrbT;

   // Output colour, GGGRRRBBB
   typedef struct packed {
      logic [2:0] green;
      logic [2:0] red;
      logic [2:0] blue;
   } grb9T;

   // ULAplus palette entry, GGGRRRBB
   typedef struct packed {
      logic [2:0] green;
      logic [2:0] red;
      logic [1:0] blue;
   } grb8T;

   typedef struct packed {
      logic       flash;
      logic       bright;
      logic [2:0] paper;
      logic [2:0] ink;
   } attrT;

   typedef logic [5:0] palIndexT;

endpackage

// File: verilog/ulaVideo_cfg.svh
`ifndef ULAVIDEO_CFG_SVH
`define ULAVIDEO_CFG_SVH

// Frame geometry in clk7 cycles and lines
`define H_TOTAL      448
`define V_TOTAL      312
`define PAPER_W      256
`define PAPER_H      192

// Sync pulse placement, both ends inclusive
`define HSYNC_BEGIN  344
`define HSYNC_END    376
`define VSYNC_BEGIN  248
`define VSYNC_END    251

// Interrupt pulse length, starting at hc 0 of line VSYNC_BEGIN
`define INT_WIDTH    64

// Fetch runs this far ahead of the displayed column
`define FETCH_OFFSET 8

// From the hc of a pixel's column to r/g/b
`define PIXEL_LAG    14

`define FLASH_FRAMES 16

// CPU I/O ports; port 0xFE is any even address
`define PORT_ULAPLUS_ADDR 16'hBF3B
`define PORT_ULAPLUS_DATA 16'hFF3B

`endif
